//--- src/dlx_isa_pkg.sv
package dlx_isa_pkg;

   // data word or byte address
   typedef logic [31:0] word_t;
   // raw instruction word
   typedef logic [31:0] instr_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;
   typedef logic [15:0] imm_t;

   // major opcodes, bits 31:26
   localparam opcode_t OP_RTYPE = 6'h00;
   localparam opcode_t OP_J     = 6'h02;
   localparam opcode_t OP_JAL   = 6'h03;
   localparam opcode_t OP_BEQZ  = 6'h04;
   localparam opcode_t OP_BNEZ  = 6'h05;
   localparam opcode_t OP_ADDI  = 6'h08;
   localparam opcode_t OP_ANDI  = 6'h0c;
   localparam opcode_t OP_ORI   = 6'h0d;
   localparam opcode_t OP_TRAP  = 6'h11;
   localparam opcode_t OP_LB    = 6'h20;
   localparam opcode_t OP_LW    = 6'h23;
   localparam opcode_t OP_SW    = 6'h2b;

   // r-type function codes, bits 5:0
   localparam funct_t FN_NOP = 6'h15;
   localparam funct_t FN_ADD = 6'h20;
   localparam funct_t FN_SUB = 6'h22;
   localparam funct_t FN_AND = 6'h24;
   localparam funct_t FN_OR  = 6'h25;
   localparam funct_t FN_XOR = 6'h26;
   localparam funct_t FN_SLT = 6'h2a;

   // r-type word with funct nop and every other field zero
   localparam instr_t INSTR_NOP = 32'h0000_0015;
   // jal link register
   localparam reg_idx_t REG_LINK = 5'd31;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
   } alu_op_t;

endpackage

//--- src/dlx_pipe_pkg.sv
package dlx_pipe_pkg;
   import dlx_isa_pkg::*;

   typedef struct packed {
      logic   valid;
      instr_t instr;
      word_t  pc_plus4;
   } if_id_t;

   typedef struct packed {
      logic     valid;
      alu_op_t  alu_op;
      logic     alu_src_imm;
      logic     sign_ext;
      imm_t     imm;
      reg_idx_t rs1;
      reg_idx_t rs2;
      word_t    rs1_val;
      word_t    rs2_val;
      reg_idx_t rd;
      logic     reg_write;
      logic     mem_read;
      logic     mem_write;
      logic     load_byte;
      // jal, operand b becomes pc_plus4
      logic     is_link;
      word_t    pc_plus4;
      logic     is_trap;
   } id_ex_t;

   typedef struct packed {
      logic     valid;
      word_t    alu_result;
      word_t    store_data;
      reg_idx_t rd;
      logic     reg_write;
      logic     mem_read;
      logic     mem_write;
      logic     load_byte;
      logic     is_trap;
   } ex_mem_t;

   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      logic     reg_write;
      word_t    wb_data;
      logic     is_trap;
   } mem_wb_t;

   // one bypass source, a result that is not yet in the register file
   typedef struct packed {
      logic     reg_write;
      reg_idx_t rd;
      word_t    value;
   } fwd_t;

   // bypass mux, the younger source wins, r0 is never bypassed
   function automatic word_t fwd_pick(fwd_t fwd_new, fwd_t fwd_old, reg_idx_t sel,
                                      word_t base);
      if (sel != '0 && fwd_new.reg_write && fwd_new.rd == sel) return fwd_new.value;
      if (sel != '0 && fwd_old.reg_write && fwd_old.rd == sel) return fwd_old.value;
      return base;
   endfunction

endpackage

//--- src/dlx_fetch.sv
module dlx_fetch import dlx_isa_pkg::*, dlx_pipe_pkg::*; #(
   parameter int IMEM_WORDS = 256
) (
   input  logic   clk,
   input  logic   rst_n,
   input  logic   stall,
   input  logic   redirect,
   input  word_t  redirect_pc,
   input  logic   prog_we,
   input  word_t  prog_addr,
   input  instr_t prog_data,
   output if_id_t if_id
);
   localparam int IA_W = $clog2(IMEM_WORDS);

   instr_t imem [IMEM_WORDS];
   // byte address of the word being fetched
   word_t  pc;
   word_t  pc_plus4;
   instr_t fetch_word;
   // set once a trap has been fetched and not killed
   logic   fetch_halt;

   // program port, word addressed, only while reset is held
   always_ff @(posedge clk) begin
      if (!rst_n && prog_we) begin
         imem[prog_addr[IA_W-1:0]] <= prog_data;
      end
   end

   assign fetch_word = imem[pc[IA_W+1:2]];
   assign pc_plus4   = pc + 32'd4;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc          <= '0;
         if_id.valid <= 1'b0;
         fetch_halt  <= 1'b0;
      end else if (redirect) begin
         // taken branch or jump, the word fetched this cycle is dropped
         pc          <= redirect_pc;
         if_id.valid <= 1'b0;
      end else if (!stall) begin
         if_id.instr    <= fetch_word;
         if_id.pc_plus4 <= pc_plus4;
         if_id.valid    <= !fetch_halt;
         if (!fetch_halt) begin
            // trap freezes the pc, later slots go out as bubbles
            if (fetch_word[31:26] == OP_TRAP) begin
               fetch_halt <= 1'b1;
            end else begin
               pc <= pc_plus4;
            end
         end
      end
   end

endmodule

//--- src/dlx_regfile.sv
module dlx_regfile import dlx_isa_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t rs1_sel,
   input  reg_idx_t rs2_sel,
   input  reg_idx_t wr_sel,
   input  logic     wr_en,
   input  word_t    wr_data,
   output word_t    rs1_val,
   output word_t    rs2_val
);
   // r0 has no storage
   word_t regs [1:31];

   // write-through, a same-cycle write shows up on the read port
   function automatic word_t read_port(reg_idx_t sel);
      if (sel == '0) return '0;
      if (wr_en && wr_sel == sel) return wr_data;
      return regs[sel];
   endfunction

   always_comb begin
      rs1_val = read_port(rs1_sel);
      rs2_val = read_port(rs2_sel);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && wr_sel != '0) begin
         regs[wr_sel] <= wr_data;
      end
   end

endmodule

//--- src/dlx_decode.sv
module dlx_decode import dlx_isa_pkg::*, dlx_pipe_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,
   input  if_id_t if_id,
   input  fwd_t   fwd_mem,
   input  fwd_t   fwd_wb,
   output id_ex_t id_ex,
   output logic   stall,
   output logic   redirect,
   output word_t  redirect_pc
);
   opcode_t  opcode;
   funct_t   funct;
   reg_idx_t rs1_sel;
   reg_idx_t rs2_sel;
   word_t    rs1_rf;
   word_t    rs2_rf;
   word_t    rs1_val;
   word_t    rs2_val;
   word_t    br_off;
   word_t    jmp_off;
   logic     use_rs1;
   logic     use_rs2;
   logic     is_branch;
   logic     is_jump;
   logic     taken;
   logic     load_use;
   logic     br_dep;
   // load now in EX/MEM, its data is not on fwd_mem yet
   logic     ld_mem_valid;
   reg_idx_t ld_mem_rd;
   id_ex_t   id_ex_d;

   assign opcode  = if_id.instr[31:26];
   assign funct   = if_id.instr[5:0];
   assign rs1_sel = if_id.instr[25:21];
   assign rs2_sel = if_id.instr[20:16];
   assign br_off  = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
   assign jmp_off = {{6{if_id.instr[25]}}, if_id.instr[25:0]};

   // write port comes straight from the MEM/WB bypass
   dlx_regfile regfile_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .rs1_sel (rs1_sel),
      .rs2_sel (rs2_sel),
      .wr_sel  (fwd_wb.rd),
      .wr_en   (fwd_wb.reg_write),
      .wr_data (fwd_wb.value),
      .rs1_val (rs1_rf),
      .rs2_val (rs2_rf)
   );

   assign rs1_val = fwd_pick(fwd_mem, fwd_wb, rs1_sel, rs1_rf);
   assign rs2_val = fwd_pick(fwd_mem, fwd_wb, rs2_sel, rs2_rf);

   always_comb begin
      id_ex_d          = '0;
      id_ex_d.valid    = if_id.valid;
      id_ex_d.alu_op   = ALU_ADD;
      id_ex_d.imm      = if_id.instr[15:0];
      id_ex_d.rs1      = rs1_sel;
      id_ex_d.rs2      = rs2_sel;
      id_ex_d.rs1_val  = rs1_val;
      id_ex_d.rs2_val  = rs2_val;
      // i-type destination by default
      id_ex_d.rd       = rs2_sel;
      id_ex_d.pc_plus4 = if_id.pc_plus4;
      use_rs1          = 1'b0;
      use_rs2          = 1'b0;
      is_branch        = 1'b0;
      is_jump          = 1'b0;
      if (if_id.valid) begin
         case (opcode)
            OP_RTYPE: begin
               id_ex_d.rd        = if_id.instr[15:11];
               // nop and unknown funct codes retire with no effect
               id_ex_d.reg_write = funct inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLT};
               use_rs1           = id_ex_d.reg_write;
               use_rs2           = id_ex_d.reg_write;
               case (funct)
                  FN_SUB:  id_ex_d.alu_op = ALU_SUB;
                  FN_AND:  id_ex_d.alu_op = ALU_AND;
                  FN_OR:   id_ex_d.alu_op = ALU_OR;
                  FN_XOR:  id_ex_d.alu_op = ALU_XOR;
                  FN_SLT:  id_ex_d.alu_op = ALU_SLT;
                  default: id_ex_d.alu_op = ALU_ADD;
               endcase
            end
            OP_ADDI, OP_ANDI, OP_ORI: begin
               id_ex_d.alu_src_imm = 1'b1;
               id_ex_d.reg_write   = 1'b1;
               // logical immediates are zero extended
               id_ex_d.sign_ext    = (opcode == OP_ADDI);
               id_ex_d.alu_op      = (opcode == OP_ANDI) ? ALU_AND :
                                     (opcode == OP_ORI)  ? ALU_OR  : ALU_ADD;
               use_rs1             = 1'b1;
            end
            OP_LW, OP_LB: begin
               id_ex_d.alu_src_imm = 1'b1;
               id_ex_d.sign_ext    = 1'b1;
               id_ex_d.mem_read    = 1'b1;
               id_ex_d.reg_write   = 1'b1;
               id_ex_d.load_byte   = (opcode == OP_LB);
               use_rs1             = 1'b1;
            end
            OP_SW: begin
               id_ex_d.alu_src_imm = 1'b1;
               id_ex_d.sign_ext    = 1'b1;
               id_ex_d.mem_write   = 1'b1;
               // rs2 field holds the store data register
               use_rs1             = 1'b1;
               use_rs2             = 1'b1;
            end
            OP_BEQZ, OP_BNEZ: begin
               is_branch = 1'b1;
               use_rs1   = 1'b1;
            end
            OP_J: is_jump = 1'b1;
            OP_JAL: begin
               is_jump           = 1'b1;
               id_ex_d.is_link   = 1'b1;
               id_ex_d.reg_write = 1'b1;
               id_ex_d.rd        = REG_LINK;
               id_ex_d.alu_op    = ALU_PASS_B;
            end
            OP_TRAP: id_ex_d.is_trap = 1'b1;
            default: ;
         endcase
      end
   end

   // load-use, the loaded value exists only after the memory stage
   assign load_use = id_ex.valid && id_ex.mem_read && id_ex.rd != '0 &&
                     ((use_rs1 && rs1_sel == id_ex.rd) || (use_rs2 && rs2_sel == id_ex.rd));
   // branch needs its operand now, wait for results still in flight
   assign br_dep   = is_branch && rs1_sel != '0 &&
                     ((id_ex.reg_write && id_ex.rd == rs1_sel) ||
                      (ld_mem_valid && ld_mem_rd == rs1_sel));
   assign stall    = load_use || br_dep;

   assign taken       = is_jump || (is_branch && ((rs1_val == '0) == (opcode == OP_BEQZ)));
   assign redirect    = taken && !stall;
   assign redirect_pc = if_id.pc_plus4 + (is_jump ? jmp_off : br_off);

   // ID/EX, a stall sends a bubble down
   always_ff @(posedge clk) begin
      id_ex <= id_ex_d;
      if (!rst_n || stall) begin
         id_ex.valid     <= 1'b0;
         id_ex.reg_write <= 1'b0;
         id_ex.mem_read  <= 1'b0;
         id_ex.mem_write <= 1'b0;
         id_ex.is_trap   <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ld_mem_valid <= 1'b0;
      end else begin
         ld_mem_valid <= id_ex.mem_read && id_ex.reg_write;
      end
      ld_mem_rd <= id_ex.rd;
   end

endmodule

//--- src/dlx_execute.sv
module dlx_execute import dlx_isa_pkg::*, dlx_pipe_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  id_ex_t  id_ex,
   input  fwd_t    fwd_wb,
   output ex_mem_t ex_mem,
   output fwd_t    fwd_mem
);
   word_t   op_a;
   word_t   rs2_val;
   word_t   ext_imm;
   word_t   op_b;
   word_t   alu_out;
   ex_mem_t ex_mem_d;

   // EX/MEM has priority over MEM/WB
   assign op_a    = fwd_pick(fwd_mem, fwd_wb, id_ex.rs1, id_ex.rs1_val);
   assign rs2_val = fwd_pick(fwd_mem, fwd_wb, id_ex.rs2, id_ex.rs2_val);

   assign ext_imm = id_ex.sign_ext ? {{16{id_ex.imm[15]}}, id_ex.imm} : {16'b0, id_ex.imm};

   // jal routes its return address through operand b
   assign op_b = id_ex.is_link     ? id_ex.pc_plus4 :
                 id_ex.alu_src_imm ? ext_imm        : rs2_val;

   always_comb begin
      case (id_ex.alu_op)
         ALU_ADD: alu_out = op_a + op_b;
         ALU_SUB: alu_out = op_a - op_b;
         ALU_AND: alu_out = op_a & op_b;
         ALU_OR:  alu_out = op_a | op_b;
         ALU_XOR: alu_out = op_a ^ op_b;
         // signed compare
         ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
         // pass_b
         default: alu_out = op_b;
      endcase
   end

   always_comb begin
      ex_mem_d            = '0;
      ex_mem_d.valid      = id_ex.valid;
      ex_mem_d.alu_result = alu_out;
      // store data after bypass
      ex_mem_d.store_data = rs2_val;
      ex_mem_d.rd         = id_ex.rd;
      ex_mem_d.reg_write  = id_ex.reg_write;
      ex_mem_d.mem_read   = id_ex.mem_read;
      ex_mem_d.mem_write  = id_ex.mem_write;
      ex_mem_d.load_byte  = id_ex.load_byte;
      ex_mem_d.is_trap    = id_ex.is_trap;
   end

   always_ff @(posedge clk) begin
      ex_mem <= ex_mem_d;
      if (!rst_n) begin
         ex_mem.valid     <= 1'b0;
         ex_mem.reg_write <= 1'b0;
         ex_mem.mem_read  <= 1'b0;
         ex_mem.mem_write <= 1'b0;
         ex_mem.is_trap   <= 1'b0;
      end
   end

   // a load holds its address here, not its data, so it is not offered
   assign fwd_mem.reg_write = ex_mem.reg_write && !ex_mem.mem_read;
   assign fwd_mem.rd        = ex_mem.rd;
   assign fwd_mem.value     = ex_mem.alu_result;

endmodule

//--- src/dlx_memory.sv
module dlx_memory import dlx_isa_pkg::*, dlx_pipe_pkg::*; #(
   parameter int DMEM_WORDS = 256
) (
   input  logic    clk,
   input  logic    rst_n,
   input  ex_mem_t ex_mem,
   output fwd_t    fwd_wb,
   output mem_wb_t mem_wb,
   output logic    st_valid,
   output word_t   st_addr,
   output word_t   st_data
);
   localparam int DA_W = $clog2(DMEM_WORDS);

   word_t           dmem [DMEM_WORDS];
   logic [DA_W-1:0] word_addr;
   word_t           rd_word;
   logic [7:0]      rd_byte;
   word_t           load_val;

   // byte address from the ALU, low two bits pick the byte
   assign word_addr = ex_mem.alu_result[DA_W+1:2];
   assign rd_word   = dmem[word_addr];
   // little-endian byte lane
   assign rd_byte   = rd_word[8*ex_mem.alu_result[1:0] +: 8];
   assign load_val  = ex_mem.load_byte ? {{24{rd_byte[7]}}, rd_byte} : rd_word;

   always_ff @(posedge clk) begin
      if (ex_mem.valid && ex_mem.mem_write) begin
         dmem[word_addr] <= ex_mem.store_data;
      end
   end

   // store trace, same cycle as the write
   assign st_valid = ex_mem.valid && ex_mem.mem_write;
   assign st_addr  = ex_mem.alu_result;
   assign st_data  = ex_mem.store_data;

   // MEM/WB, writeback mux folded in front of the register
   always_ff @(posedge clk) begin
      mem_wb.rd      <= ex_mem.rd;
      mem_wb.wb_data <= ex_mem.mem_read ? load_val : ex_mem.alu_result;
      if (!rst_n) begin
         mem_wb.valid     <= 1'b0;
         mem_wb.reg_write <= 1'b0;
         mem_wb.is_trap   <= 1'b0;
      end else begin
         mem_wb.valid     <= ex_mem.valid;
         mem_wb.reg_write <= ex_mem.reg_write;
         mem_wb.is_trap   <= ex_mem.is_trap;
      end
   end

   assign fwd_wb.reg_write = mem_wb.reg_write;
   assign fwd_wb.rd        = mem_wb.rd;
   assign fwd_wb.value     = mem_wb.wb_data;

endmodule

//--- src/dlx_core.sv
module dlx_core import dlx_isa_pkg::*, dlx_pipe_pkg::*; #(
   parameter int IMEM_WORDS = 256,
   parameter int DMEM_WORDS = 256
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     prog_we,
   input  word_t    prog_addr,
   input  instr_t   prog_data,
   output logic     wb_valid,
   output reg_idx_t wb_rd,
   output word_t    wb_data,
   output logic     st_valid,
   output word_t    st_addr,
   output word_t    st_data,
   output logic     halted
);
   if_id_t  if_id;
   id_ex_t  id_ex;
   ex_mem_t ex_mem;
   mem_wb_t mem_wb;
   fwd_t    fwd_mem;
   fwd_t    fwd_wb;
   // decode back to fetch
   logic    stall;
   logic    redirect;
   word_t   redirect_pc;

   dlx_fetch #(.IMEM_WORDS(IMEM_WORDS)) fetch_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .prog_we     (prog_we),
      .prog_addr   (prog_addr),
      .prog_data   (prog_data),
      .if_id       (if_id)
   );

   dlx_decode decode_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .if_id       (if_id),
      .fwd_mem     (fwd_mem),
      .fwd_wb      (fwd_wb),
      .id_ex       (id_ex),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

   dlx_execute execute_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .id_ex   (id_ex),
      .fwd_wb  (fwd_wb),
      .ex_mem  (ex_mem),
      .fwd_mem (fwd_mem)
   );

   dlx_memory #(.DMEM_WORDS(DMEM_WORDS)) memory_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .ex_mem   (ex_mem),
      .fwd_wb   (fwd_wb),
      .mem_wb   (mem_wb),
      .st_valid (st_valid),
      .st_addr  (st_addr),
      .st_data  (st_data)
   );

   // retired register writes, r0 writes are dropped from the trace
   assign wb_valid = mem_wb.valid && mem_wb.reg_write && mem_wb.rd != '0;
   assign wb_rd    = mem_wb.rd;
   assign wb_data  = mem_wb.wb_data;

   // sticky until reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         halted <= 1'b0;
      end else if (mem_wb.valid && mem_wb.is_trap) begin
         halted <= 1'b1;
      end
   end

endmodule

//--- tb/dlx_core_props.sv
module dlx_core_props import dlx_isa_pkg::*; (
   input logic     clk,
   input logic     rst_n,
   input logic     prog_we,
   input logic     wb_valid,
   input reg_idx_t wb_rd,
   input logic     st_valid,
   input logic     halted
);
   timeunit 1ns;
   timeprecision 100ps;

   // a reset cycle leaves both traces and halted low
   reset_clears: assert property (@(posedge clk) !rst_n |=> !wb_valid && !st_valid && !halted)
      else $error("trace outputs or halted high after a reset cycle");

   // halted is sticky
   halted_sticky: assert property (@(posedge clk) halted && rst_n |=> halted)
      else $error("halted dropped without reset");

   // r0 writes are filtered out of the trace
   wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> wb_rd != '0)
      else $error("writeback trace shows r0");

   prog_in_reset: assert property (@(posedge clk) prog_we |-> !rst_n)
      else $error("program port written outside reset");

endmodule

bind dlx_core dlx_core_props props_i (
   .clk      (clk),
   .rst_n    (rst_n),
   .prog_we  (prog_we),
   .wb_valid (wb_valid),
   .wb_rd    (wb_rd),
   .st_valid (st_valid),
   .halted   (halted)
);

//--- tb/dlx_ref_model.svh
`ifndef DLX_REF_MODEL_SVH
`define DLX_REF_MODEL_SVH

// one expected register write on the writeback trace
typedef struct packed {
   reg_idx_t rd;
   word_t    data;
} wb_exp_t;

// one expected store on the store trace
typedef struct packed {
   word_t addr;
   word_t data;
} st_exp_t;

// program under test and what it should produce
instr_t  prog_q [$];
wb_exp_t exp_wb [$];
st_exp_t exp_st [$];

function automatic instr_t rtype(funct_t fn, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
   return {OP_RTYPE, rs1, rs2, rd, 5'd0, fn};
endfunction

// immediate format
// for sw the rd slot holds the data register and for branches it is zero
function automatic instr_t itype(opcode_t op, reg_idx_t rd, reg_idx_t rs1, imm_t imm);
   return {op, rs1, rd, imm};
endfunction

// jump format with a 26 bit byte offset
function automatic instr_t jtype(opcode_t op, logic [25:0] off);
   return {op, off};
endfunction

// runs prog_q at instruction level and fills exp_wb and exp_st
function automatic void run_model();
   word_t      regs [32];
   word_t      dmem [256];
   word_t      pc;
   word_t      next_pc;
   word_t      a;
   word_t      b;
   word_t      sx;
   word_t      zx;
   word_t      ea;
   word_t      res;
   logic       wr;
   reg_idx_t   wr_rd;
   instr_t     iw;
   logic [7:0] byte_v;
   regs = '{default: '0};
   dmem = '{default: '0};
   exp_wb.delete();
   exp_st.delete();
   pc = '0;
   for (int step = 0; step < 4096; step++) begin
      // running off the end of the program
      if (pc[31:2] >= prog_q.size()) begin
         break;
      end
      iw      = prog_q[pc[31:2]];
      a       = regs[iw[25:21]];
      b       = regs[iw[20:16]];
      sx      = {{16{iw[15]}}, iw[15:0]};
      zx      = {16'b0, iw[15:0]};
      ea      = a + sx;
      next_pc = pc + 32'd4;
      wr      = 1'b1;
      wr_rd   = iw[20:16];
      res     = '0;
      case (iw[31:26])
         OP_RTYPE: begin
            wr_rd = iw[15:11];
            case (iw[5:0])
               FN_ADD:  res = a + b;
               FN_SUB:  res = a - b;
               FN_AND:  res = a & b;
               FN_OR:   res = a | b;
               FN_XOR:  res = a ^ b;
               FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               // nop and anything unknown
               default: wr = 1'b0;
            endcase
         end
         OP_ADDI: res = a + sx;
         OP_ANDI: res = a & zx;
         OP_ORI:  res = a | zx;
         OP_LW:   res = dmem[ea[9:2]];
         OP_LB: begin
            // little endian lane then sign extension
            res    = dmem[ea[9:2]] >> (8 * ea[1:0]);
            byte_v = res[7:0];
            res    = {{24{byte_v[7]}}, byte_v};
         end
         OP_SW: begin
            wr = 1'b0;
            dmem[ea[9:2]] = b;
            exp_st.push_back(st_exp_t'{addr: ea, data: b});
         end
         OP_BEQZ, OP_BNEZ: begin
            wr = 1'b0;
            if (iw[31:26] == OP_BEQZ ? a == '0 : a != '0) begin
               next_pc = pc + 32'd4 + sx;
            end
         end
         OP_J: begin
            wr      = 1'b0;
            next_pc = pc + 32'd4 + {{6{iw[25]}}, iw[25:0]};
         end
         OP_JAL: begin
            wr_rd   = 5'd31;
            res     = pc + 32'd4;
            next_pc = pc + 32'd4 + {{6{iw[25]}}, iw[25:0]};
         end
         OP_TRAP: return;
         default: wr = 1'b0;
      endcase
      // r0 writes leave no trace
      if (wr && wr_rd != '0) begin
         regs[wr_rd] = res;
         exp_wb.push_back(wb_exp_t'{rd: wr_rd, data: res});
      end
      pc = next_pc;
   end
endfunction

`endif

//--- tb/dlx_core_tb.sv
module dlx_core_tb import dlx_isa_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT_CYCLES = 2000;

   logic     clk;
   logic     rst_n;
   logic     prog_we;
   word_t    prog_addr;
   instr_t   prog_data;
   logic     wb_valid;
   reg_idx_t wb_rd;
   word_t    wb_data;
   logic     st_valid;
   word_t    st_addr;
   word_t    st_data;
   logic     halted;

   integer   seed = 32'hc3e46ac8;
   int       n_checks;
   int       n_errors;
   int       test_errors;

   `include "dlx_ref_model.svh"

   // head entries popped by the compare process
   wb_exp_t  wb_head;
   st_exp_t  st_head;

   dlx_core #(.IMEM_WORDS(256), .DMEM_WORDS(256)) dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .wb_valid  (wb_valid),
      .wb_rd     (wb_rd),
      .wb_data   (wb_data),
      .st_valid  (st_valid),
      .st_addr   (st_addr),
      .st_data   (st_data),
      .halted    (halted)
   );

   // 40 ns period
   always #20 clk = ~clk;

   task automatic check_word(input word_t got, input word_t exp, input string name);
      n_checks++;
      if (got !== exp) begin
         test_errors++;
         $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_reg(input reg_idx_t got, input reg_idx_t exp, input string name);
      n_checks++;
      if (got !== exp) begin
         test_errors++;
         $display("error at %0t ns: %s is r%0d, expected r%0d", $time, name, got, exp);
      end
   endtask

   task automatic report_problem(input string msg);
      test_errors++;
      $display("%0t ns: %s", $time, msg);
   endtask

   // traces are stable mid-cycle
   always @(negedge clk) begin
      if (rst_n === 1'b1) begin
         if (wb_valid) begin
            if (exp_wb.size() == 0) begin
               report_problem($sformatf("unexpected write to r%0d on the writeback trace", wb_rd));
            end else begin
               wb_head = exp_wb.pop_front();
               check_reg(wb_rd, wb_head.rd, "wb_rd");
               check_word(wb_data, wb_head.data, "wb_data");
            end
         end
         if (st_valid) begin
            if (exp_st.size() == 0) begin
               report_problem($sformatf("unexpected store to %h on the store trace", st_addr));
            end else begin
               st_head = exp_st.pop_front();
               check_word(st_addr, st_head.addr, "st_addr");
               check_word(st_data, st_head.data, "st_data");
            end
         end
      end
   end

   // program goes in while the core is held in reset
   task automatic load_program();
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      foreach (prog_q[i]) begin
         prog_we   = 1'b1;
         prog_addr = word_t'(i);
         prog_data = prog_q[i];
         @(posedge clk);
         #1;
      end
      prog_we = 1'b0;
      // three more reset cycles past the last program word
      repeat (3) begin
         @(posedge clk);
         #1;
      end
      rst_n = 1'b1;
   endtask

   task automatic run_test(input string name);
      int cycles;
      int first_check;
      test_errors = 0;
      first_check = n_checks;
      run_model();
      load_program();
      cycles = 0;
      while (halted !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycles++;
      end
      if (halted !== 1'b1) begin
         report_problem($sformatf("timeout, halted did not rise in %0d cycles", TIMEOUT_CYCLES));
      end
      // let the compare process see the final cycle
      @(negedge clk);
      if (exp_wb.size() != 0) begin
         report_problem($sformatf("%0d register writes never retired", exp_wb.size()));
      end
      if (exp_st.size() != 0) begin
         report_problem($sformatf("%0d stores never appeared", exp_st.size()));
      end
      n_errors += test_errors;
      $display("test %s: %0d checks, %0d errors", name, n_checks - first_check, test_errors);
      prog_q.delete();
   endtask

   // straight-line ALU mix over r0 to r7 so most operands come from a bypass
   task automatic build_random();
      int       n;
      int       kind;
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
      imm_t     imm;
      n = 8 + ($unsigned($random(seed)) % 16);
      for (int i = 0; i < n; i++) begin
         kind = $unsigned($random(seed)) % 9;
         rd   = reg_idx_t'($unsigned($random(seed)) % 8);
         rs1  = reg_idx_t'($unsigned($random(seed)) % 8);
         rs2  = reg_idx_t'($unsigned($random(seed)) % 8);
         imm  = imm_t'($random(seed));
         case (kind)
            0:       prog_q.push_back(rtype(FN_ADD, rd, rs1, rs2));
            1:       prog_q.push_back(rtype(FN_SUB, rd, rs1, rs2));
            2:       prog_q.push_back(rtype(FN_AND, rd, rs1, rs2));
            3:       prog_q.push_back(rtype(FN_OR, rd, rs1, rs2));
            4:       prog_q.push_back(rtype(FN_XOR, rd, rs1, rs2));
            5:       prog_q.push_back(rtype(FN_SLT, rd, rs1, rs2));
            6:       prog_q.push_back(itype(OP_ADDI, rd, rs1, imm));
            7:       prog_q.push_back(itype(OP_ANDI, rd, rs1, imm));
            default: prog_q.push_back(itype(OP_ORI, rd, rs1, imm));
         endcase
      end
      prog_q.push_back(jtype(OP_TRAP, '0));
   endtask

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      prog_we   = 1'b0;
      prog_addr = '0;
      prog_data = INSTR_NOP;
      n_checks  = 0;
      n_errors  = 0;

      // dependent ALU chain through EX/MEM and MEM/WB
      prog_q.push_back(itype(OP_ADDI, 5'd1, 5'd0, 16'd5));
      prog_q.push_back(itype(OP_ADDI, 5'd2, 5'd1, 16'd7));
      prog_q.push_back(rtype(FN_ADD, 5'd3, 5'd1, 5'd2));
      prog_q.push_back(rtype(FN_SUB, 5'd4, 5'd3, 5'd1));
      prog_q.push_back(rtype(FN_AND, 5'd5, 5'd4, 5'd3));
      prog_q.push_back(rtype(FN_OR, 5'd6, 5'd5, 5'd2));
      prog_q.push_back(rtype(FN_XOR, 5'd7, 5'd6, 5'd4));
      prog_q.push_back(rtype(FN_SLT, 5'd8, 5'd4, 5'd7));
      prog_q.push_back(itype(OP_ORI, 5'd9, 5'd0, 16'hf0f0));
      prog_q.push_back(itype(OP_ANDI, 5'd10, 5'd9, 16'hff00));
      prog_q.push_back(itype(OP_ADDI, 5'd11, 5'd0, 16'hfffd));
      prog_q.push_back(rtype(FN_SLT, 5'd12, 5'd11, 5'd1));
      prog_q.push_back(jtype(OP_TRAP, '0));
      run_test("alu_forwarding");

      // stores then word and byte loads with load-use pairs
      prog_q.push_back(itype(OP_ADDI, 5'd1, 5'd0, 16'h0040));
      prog_q.push_back(itype(OP_ORI, 5'd2, 5'd0, 16'ha5c3));
      prog_q.push_back(itype(OP_SW, 5'd2, 5'd1, 16'd0));
      prog_q.push_back(itype(OP_ADDI, 5'd3, 5'd0, 16'h0077));
      prog_q.push_back(itype(OP_SW, 5'd3, 5'd1, 16'd4));
      prog_q.push_back(itype(OP_LW, 5'd4, 5'd1, 16'd0));
      prog_q.push_back(rtype(FN_ADD, 5'd5, 5'd4, 5'd4));
      prog_q.push_back(itype(OP_LB, 5'd6, 5'd1, 16'd0));
      prog_q.push_back(itype(OP_LB, 5'd7, 5'd1, 16'd1));
      prog_q.push_back(itype(OP_LB, 5'd8, 5'd1, 16'd4));
      prog_q.push_back(itype(OP_ADDI, 5'd9, 5'd8, 16'd1));
      prog_q.push_back(itype(OP_SW, 5'd6, 5'd1, 16'd8));
      prog_q.push_back(itype(OP_LW, 5'd10, 5'd1, 16'd8));
      prog_q.push_back(itype(OP_SW, 5'd10, 5'd1, 16'd12));
      prog_q.push_back(jtype(OP_TRAP, '0));
      run_test("load_store");

      // taken and not-taken branches with a short loop
      prog_q.push_back(itype(OP_ADDI, 5'd1, 5'd0, 16'd3));
      prog_q.push_back(itype(OP_ADDI, 5'd2, 5'd0, 16'd0));
      prog_q.push_back(itype(OP_BEQZ, 5'd0, 5'd2, 16'd8));
      prog_q.push_back(itype(OP_ADDI, 5'd3, 5'd0, 16'd111));
      prog_q.push_back(itype(OP_ADDI, 5'd4, 5'd0, 16'd222));
      prog_q.push_back(itype(OP_BNEZ, 5'd0, 5'd2, 16'd8));
      prog_q.push_back(itype(OP_ADDI, 5'd5, 5'd0, 16'd5));
      prog_q.push_back(itype(OP_ADDI, 5'd6, 5'd6, 16'd2));
      prog_q.push_back(itype(OP_ADDI, 5'd1, 5'd1, 16'hffff));
      prog_q.push_back(itype(OP_BNEZ, 5'd0, 5'd1, 16'hfff4));
      prog_q.push_back(itype(OP_ADDI, 5'd7, 5'd0, 16'd9));
      prog_q.push_back(itype(OP_BEQZ, 5'd0, 5'd7, 16'd4));
      prog_q.push_back(itype(OP_BEQZ, 5'd0, 5'd1, 16'd4));
      prog_q.push_back(itype(OP_ADDI, 5'd8, 5'd0, 16'd1));
      prog_q.push_back(jtype(OP_TRAP, '0));
      run_test("branches");

      // j and jal skip two words each
      prog_q.push_back(itype(OP_ADDI, 5'd1, 5'd0, 16'd1));
      prog_q.push_back(jtype(OP_J, 26'd8));
      prog_q.push_back(itype(OP_ADDI, 5'd2, 5'd0, 16'd2));
      prog_q.push_back(itype(OP_ADDI, 5'd3, 5'd0, 16'd3));
      prog_q.push_back(jtype(OP_JAL, 26'd8));
      prog_q.push_back(itype(OP_ADDI, 5'd4, 5'd0, 16'd4));
      prog_q.push_back(itype(OP_ADDI, 5'd5, 5'd0, 16'd5));
      prog_q.push_back(rtype(FN_ADD, 5'd6, 5'd31, 5'd1));
      prog_q.push_back(itype(OP_BNEZ, 5'd0, 5'd31, 16'd4));
      prog_q.push_back(itype(OP_ADDI, 5'd7, 5'd0, 16'd7));
      prog_q.push_back(jtype(OP_TRAP, '0));
      run_test("jumps");

      // r0 as destination of ALU ops and of a load
      prog_q.push_back(itype(OP_ADDI, 5'd0, 5'd0, 16'd55));
      prog_q.push_back(itype(OP_ORI, 5'd1, 5'd0, 16'd7));
      prog_q.push_back(rtype(FN_ADD, 5'd0, 5'd1, 5'd1));
      prog_q.push_back(rtype(FN_ADD, 5'd2, 5'd0, 5'd1));
      prog_q.push_back(itype(OP_SW, 5'd1, 5'd0, 16'h0080));
      prog_q.push_back(itype(OP_LW, 5'd0, 5'd0, 16'h0080));
      prog_q.push_back(rtype(FN_ADD, 5'd3, 5'd0, 5'd0));
      prog_q.push_back(jtype(OP_TRAP, '0));
      run_test("r0_writes");

      for (int t = 0; t < 20; t++) begin
         build_random();
         run_test($sformatf("random_%0d", t));
      end

      $display("%0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- tb.f
src/dlx_isa_pkg.sv
src/dlx_pipe_pkg.sv
src/dlx_fetch.sv
src/dlx_regfile.sv
src/dlx_decode.sv
src/dlx_execute.sv
src/dlx_memory.sv
src/dlx_core.sv
+incdir+tb
tb/dlx_core_props.sv
tb/dlx_core_tb.sv
